//--- src.f
+incdir+hw
hw/screen_pkg.sv
hw/map_pkg.sv
hw/map_control.sv
hw/char_mover.sv
hw/game_core_top.sv
dv/clk_rst_gen.sv
dv/game_core_checker.sv
dv/game_core_tb.sv

//--- Bender.yml
package:
  name: game_core

export_include_dirs:
  - hw

sources:
  - hw/screen_pkg.sv
  - hw/map_pkg.sv
  - hw/map_control.sv
  - hw/char_mover.sv
  - hw/game_core_top.sv
  - target: test
    files:
      - dv/clk_rst_gen.sv
      - dv/game_core_checker.sv
      - dv/game_core_tb.sv

//--- dv/game_core_tb.sv
// Testbench top for the movement core.
// Sends seeded random move commands on step pulses four cycles apart and
// reports the checker's error count at the end of the run.

`timescale 1ns/1ps
`default_nettype none

module game_core_tb;

    import screen_pkg::*;
    import map_pkg::*;

    localparam int NUM_STEPS   = 600;
    localparam int STEP_CYCLES = 4;
    localparam int MAX_CYCLES  = NUM_STEPS * STEP_CYCLES + 100;

    logic         clk;
    logic         rst;
    logic         step;
    move_t        move;
    coord_t       xpos;
    coord_t       ypos;
    mover_state_t state;
    logic         ladder;
    logic         end_of_ramp;
    int           error_count;
    int           cycles = 0;

    clk_rst_gen u_clk_rst_gen (
        .clk (clk),
        .rst (rst)
    );

    game_core_top DUT (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .move        (move),
        .xpos        (xpos),
        .ypos        (ypos),
        .state       (state),
        .ladder      (ladder),
        .end_of_ramp (end_of_ramp)
    );

    game_core_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .step        (step),
        .move        (move),
        .xpos        (xpos),
        .ypos        (ypos),
        .state       (state),
        .ladder      (ladder),
        .end_of_ramp (end_of_ramp),
        .error_count (error_count)
    );

    // Walking dominates, and the lean side decides which way the character drifts.
    // On a ladder the character mostly climbs so that it reaches the ramps above
    function automatic move_t pick_move(input logic lean_right, input logic on_ladder);
        int unsigned r;
        r = $urandom % 16;
        if (on_ladder) begin
            if (r < 11) begin
                pick_move = MOVE_UP;
            end else if (r < 12) begin
                pick_move = MOVE_DOWN;
            end else begin
                pick_move = lean_right ? MOVE_RIGHT : MOVE_LEFT;
            end
        end else if (r < 10) begin
            pick_move = lean_right ? MOVE_RIGHT : MOVE_LEFT;
        end else if (r < 11) begin
            pick_move = lean_right ? MOVE_LEFT : MOVE_RIGHT;
        end else if (r < 14) begin
            pick_move = MOVE_UP;
        end else if (r < 15) begin
            pick_move = MOVE_DOWN;
        end else begin
            pick_move = MOVE_NONE;
        end
    endfunction

    initial begin
        int    run_left;
        move_t cur_move;
        step = 1'b0;
        move = MOVE_NONE;
        run_left = 0;
        cur_move = MOVE_NONE;
        void'($urandom(60));
        while (rst !== 1'b0) @(posedge clk);
        repeat (2) @(posedge clk);
        // Commands repeat in short runs so the character travels across the map
        for (int i = 0; i < NUM_STEPS; i++) begin
            if (run_left == 0) begin
                cur_move = pick_move(i < 450, ladder);
                run_left = 1 + ($urandom % 16);
            end
            run_left = run_left - 1;
            @(posedge clk);
            #2;
            step = 1'b1;
            move = cur_move;
            @(posedge clk);
            #2;
            step = 1'b0;
            move = MOVE_NONE;
            repeat (STEP_CYCLES - 2) @(posedge clk);
        end
        repeat (4) @(posedge clk);
        $display("Run finished: %0d steps, %0d errors", NUM_STEPS, error_count);
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles without finishing all steps", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- dv/game_core_checker.sv
// Reference model of the map lookup and the movement FSM.
// Follows every step pulse, checks position and state one cycle later and
// the ladder and ramp-end flags one cycle after that. Counts each mismatch.

`timescale 1ns/1ps
`default_nettype none

`include "game_config.svh"

module game_core_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step,
    input  screen_pkg::move_t     move,
    input  screen_pkg::coord_t    xpos,
    input  screen_pkg::coord_t    ypos,
    input  map_pkg::mover_state_t state,
    input  logic                  ladder,
    input  logic                  end_of_ramp,
    output int                    error_count
);

    import screen_pkg::*;
    import map_pkg::*;

    localparam int X_MAX = `SCREEN_W - `CHAR_W;

    int           m_x;
    int           m_y;
    int           m_min;
    int           m_max;
    int           m_landing;
    logic         m_ladder;
    logic         m_eor;
    slope_t       m_slope;
    mover_state_t m_state;
    string        behavior;
    logic         pos_due;
    logic         map_due;
    logic         was_reset;

    function automatic logic covers(input int x0, input int x1, input int y0, input int y1);
        covers = (m_x >= x0) && (m_x <= x1) && (m_y >= y0) && (m_y <= y1);
    endfunction

    // Ladder box spans WIDTH pixels starting OFFSET left of the ladder edge
    function automatic logic on_ladder(input int hstart, input int vstart, input int vstop);
        on_ladder = covers(hstart - `LADDER_OFFSET, hstart - `LADDER_OFFSET + `LADDER_WIDTH,
                           vstart, vstop);
    endfunction

    task automatic compare_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            error_count = error_count + 1;
            $display("FAIL %s: expected %0d, actual %0d", what, expected, actual);
        end
    endtask

    // Limits and landing height keep their last value when no box matches
    task automatic lookup_zone();
        m_ladder = 1'b1;
        if (on_ladder(`LADDER_1_HSTART, `LADDER_1_VSTART, `LADDER_1_VSTOP)) begin
            m_min = `LADDER_1_VSTART;
            m_max = `LADDER_1_VSTOP;
        end else if (on_ladder(`LADDER_2_HSTART, `LADDER_2_VSTART, `LADDER_2_VSTOP)) begin
            m_min = `LADDER_2_VSTART;
            m_max = `LADDER_2_VSTOP;
        end else if (on_ladder(`LADDER_3_HSTART, `LADDER_3_VSTART, `LADDER_3_VSTOP)) begin
            m_min = `LADDER_3_VSTART;
            m_max = `LADDER_3_VSTOP;
        end else begin
            m_ladder = 1'b0;
        end
        if (covers(`RAMP_1_HSTART, `RAMP_1_HSTOP, `RAMP_1_VSTART, `RAMP_1_VSTOP)) begin
            m_slope = slope_t'(`RAMP_1_SLOPE);
        end else if (covers(`RAMP_2_HSTART, `RAMP_2_HSTOP, `RAMP_2_VSTART, `RAMP_2_VSTOP)) begin
            m_slope = slope_t'(`RAMP_2_SLOPE);
        end else begin
            m_slope = SLOPE_FLAT;
        end
        m_eor = 1'b1;
        if (covers(`EOR_1_HSTART, `EOR_1_HSTOP, `EOR_1_VSTART, `EOR_1_VSTOP)) begin
            m_landing = `LANDING_1;
        end else if (covers(`EOR_2_HSTART, `EOR_2_HSTOP, `EOR_2_VSTART, `EOR_2_VSTOP)) begin
            m_landing = `LANDING_2;
        end else begin
            m_eor = 1'b0;
        end
    endtask

    task automatic apply_step(input move_t mv);
        case (m_state)
            ST_WALK: begin
                behavior = (m_slope == SLOPE_FLAT) ? "walk" : "ramp walk";
                if (m_eor) begin
                    behavior = "ramp end";
                    m_state = ST_FALL;
                end else if (m_ladder && (mv == MOVE_UP || mv == MOVE_DOWN)) begin
                    behavior = "ladder entry";
                    m_state = ST_CLIMB;
                end else if (mv == MOVE_LEFT) begin
                    m_x = (m_x < `WALK_STEP) ? 0 : m_x - `WALK_STEP;
                    m_y = m_y + int'(m_slope == SLOPE_DOWN_LEFT) - int'(m_slope == SLOPE_DOWN_RIGHT);
                end else if (mv == MOVE_RIGHT) begin
                    m_x = (m_x + `WALK_STEP > X_MAX) ? X_MAX : m_x + `WALK_STEP;
                    m_y = m_y + int'(m_slope == SLOPE_DOWN_RIGHT) - int'(m_slope == SLOPE_DOWN_LEFT);
                end
            end
            ST_CLIMB: begin
                behavior = "climb";
                if (mv == MOVE_UP) begin
                    m_y = (m_y - `CLIMB_STEP <= m_min) ? m_min : m_y - `CLIMB_STEP;
                end else if (mv == MOVE_DOWN) begin
                    m_y = (m_y + `CLIMB_STEP >= m_max) ? m_max : m_y + `CLIMB_STEP;
                end else if ((mv == MOVE_LEFT || mv == MOVE_RIGHT) &&
                             (m_y == m_min || m_y == m_max)) begin
                    m_state = ST_WALK;
                end
            end
            default: begin
                behavior = "fall";
                if (m_y + `FALL_STEP >= m_landing) begin
                    m_y = m_landing;
                    m_state = ST_WALK;
                end else begin
                    m_y = m_y + `FALL_STEP;
                end
            end
        endcase
        lookup_zone();
    endtask

    always @(posedge clk) begin
        if (rst) begin
            m_x = `START_X;
            m_y = `START_Y;
            m_state = ST_WALK;
            m_min = 0;
            m_max = 0;
            m_landing = 0;
            lookup_zone();
            pos_due = 1'b0;
            map_due = 1'b0;
        end else begin
            map_due = pos_due;
            pos_due = step;
            if (step) begin
                apply_step(move);
            end
        end
    end

    // Outputs are compared half a cycle after the edge that updates them
    always @(negedge clk) begin
        if (rst) begin
            error_count = 0;
            was_reset = 1'b1;
        end else if (was_reset) begin
            compare_value("reset xpos", `START_X, int'(xpos));
            compare_value("reset ypos", `START_Y, int'(ypos));
            compare_value("reset state", int'(ST_WALK), int'(state));
            compare_value("reset ladder", 0, int'(ladder));
            compare_value("reset end_of_ramp", 0, int'(end_of_ramp));
            was_reset = 1'b0;
        end else begin
            if (pos_due) begin
                compare_value({behavior, " xpos"}, m_x, int'(xpos));
                compare_value({behavior, " ypos"}, m_y, int'(ypos));
                compare_value({behavior, " state"}, int'(m_state), int'(state));
            end
            if (map_due) begin
                compare_value("ladder flag", int'(m_ladder), int'(ladder));
                compare_value("end_of_ramp flag", int'(m_eor), int'(end_of_ramp));
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/clk_rst_gen.sv
// Testbench clock and reset source.
// Makes a 40 ns clock and holds reset high for the first three rising edges.

`timescale 1ns/1ps
`default_nettype none

module clk_rst_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- hw/game_core_top.sv
// Movement core top level.
// Closes the position loop between the movement FSM and the map lookup.
// Outputs follow a step pulse by one cycle.

`timescale 1ns/1ps
`default_nettype none

module game_core_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step,
    input  screen_pkg::move_t     move,
    output screen_pkg::coord_t    xpos,
    output screen_pkg::coord_t    ypos,
    output map_pkg::mover_state_t state,
    output logic                  ladder,
    output logic                  end_of_ramp
);

    import screen_pkg::*;
    import map_pkg::*;

    coord_t limit_ypos_min;
    coord_t limit_ypos_max;
    coord_t landing_ypos;
    slope_t slope;

    char_mover u_char_mover (
        .clk            (clk),
        .rst            (rst),
        .step           (step),
        .move           (move),
        .ladder         (ladder),
        .limit_ypos_min (limit_ypos_min),
        .limit_ypos_max (limit_ypos_max),
        .slope          (slope),
        .end_of_ramp    (end_of_ramp),
        .landing_ypos   (landing_ypos),
        .xpos           (xpos),
        .ypos           (ypos),
        .state          (state)
    );

    map_control u_map_control (
        .clk            (clk),
        .rst            (rst),
        .xpos           (xpos),
        .ypos           (ypos),
        .ladder         (ladder),
        .limit_ypos_min (limit_ypos_min),
        .limit_ypos_max (limit_ypos_max),
        .slope          (slope),
        .end_of_ramp    (end_of_ramp),
        .landing_ypos   (landing_ypos)
    );

endmodule

`default_nettype wire

//--- hw/char_mover.sv
// Character movement FSM.
// On each step pulse the character walks, climbs or falls according to the
// move command and the zone information from the map lookup. The new
// position and state are registered one cycle after the step.

`timescale 1ns/1ps
`default_nettype none

`include "game_config.svh"

module char_mover (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  step,
    input  screen_pkg::move_t     move,
    input  logic                  ladder,
    input  screen_pkg::coord_t    limit_ypos_min,
    input  screen_pkg::coord_t    limit_ypos_max,
    input  map_pkg::slope_t       slope,
    input  logic                  end_of_ramp,
    input  screen_pkg::coord_t    landing_ypos,
    output screen_pkg::coord_t    xpos,
    output screen_pkg::coord_t    ypos,
    output map_pkg::mover_state_t state
);

    import screen_pkg::*;
    import map_pkg::*;

    localparam coord_t X_MAX = coord_t'(`SCREEN_W - `CHAR_W);
    localparam coord_t Y_MAX = coord_t'(`SCREEN_H - `CHAR_H);
    localparam coord_t WALK  = coord_t'(`WALK_STEP);
    localparam coord_t CLIMB = coord_t'(`CLIMB_STEP);
    localparam coord_t FALL  = coord_t'(`FALL_STEP);

    coord_t       xpos_nxt;
    coord_t       ypos_nxt;
    mover_state_t state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            xpos  <= coord_t'(`START_X);
            ypos  <= coord_t'(`START_Y);
            state <= ST_WALK;
        end else begin
            xpos  <= xpos_nxt;
            ypos  <= ypos_nxt;
            state <= state_nxt;
        end
    end

    always_comb begin
        xpos_nxt  = xpos;
        ypos_nxt  = ypos;
        state_nxt = state;
        if (step) begin
            case (state)
                ST_WALK: begin
                    if (end_of_ramp) begin
                        state_nxt = ST_FALL;
                    end else if (ladder && (move == MOVE_UP || move == MOVE_DOWN)) begin
                        state_nxt = ST_CLIMB;
                    end else if (move == MOVE_LEFT) begin
                        xpos_nxt = (xpos < WALK) ? '0 : xpos - WALK;
                        if (slope == SLOPE_DOWN_LEFT) begin
                            ypos_nxt = ypos + 1'b1;
                        end else if (slope == SLOPE_DOWN_RIGHT) begin
                            ypos_nxt = ypos - 1'b1;
                        end
                    end else if (move == MOVE_RIGHT) begin
                        xpos_nxt = (xpos + WALK > X_MAX) ? X_MAX : xpos + WALK;
                        if (slope == SLOPE_DOWN_RIGHT) begin
                            ypos_nxt = ypos + 1'b1;
                        end else if (slope == SLOPE_DOWN_LEFT) begin
                            ypos_nxt = ypos - 1'b1;
                        end
                    end
                end
                ST_CLIMB: begin
                    if (move == MOVE_UP) begin
                        ypos_nxt = (ypos <= limit_ypos_min + CLIMB) ? limit_ypos_min
                                                                     : ypos - CLIMB;
                    end else if (move == MOVE_DOWN) begin
                        ypos_nxt = (ypos + CLIMB >= limit_ypos_max) ? limit_ypos_max
                                                                     : ypos + CLIMB;
                    end else if (move == MOVE_LEFT || move == MOVE_RIGHT) begin
                        // Stepping off is only allowed at the top or bottom of the ladder
                        if (ypos == limit_ypos_min || ypos == limit_ypos_max) begin
                            state_nxt = ST_WALK;
                        end
                    end
                end
                ST_FALL: begin
                    if (ypos + FALL >= landing_ypos) begin
                        ypos_nxt  = landing_ypos;
                        state_nxt = ST_WALK;
                    end else begin
                        ypos_nxt = ypos + FALL;
                    end
                end
                default: begin
                    state_nxt = ST_WALK;
                end
            endcase
        end
    end

    // Map zones and clamping together keep the character on screen
    ypos_on_screen: assert property (
        @(posedge clk) disable iff (rst)
        ypos <= Y_MAX
    ) else $error("ypos %0d below the screen bottom", ypos);

endmodule

`default_nettype wire

//--- hw/map_control.sv
// Map lookup for the character position.
// Reports ladder zones with their climbing limits, the ramp slope and
// ramp ends with a landing height. All outputs are registered and describe
// the position seen one clock earlier.

`timescale 1ns/1ps
`default_nettype none

`include "game_config.svh"

module map_control (
    input  logic               clk,
    input  logic               rst,
    input  screen_pkg::coord_t xpos,
    input  screen_pkg::coord_t ypos,
    output logic               ladder,
    output screen_pkg::coord_t limit_ypos_min,
    output screen_pkg::coord_t limit_ypos_max,
    output map_pkg::slope_t    slope,
    output logic               end_of_ramp,
    output screen_pkg::coord_t landing_ypos
);

    import screen_pkg::*;
    import map_pkg::*;

    logic   ladder_nxt;
    logic   end_of_ramp_nxt;
    coord_t limit_ypos_min_nxt;
    coord_t limit_ypos_max_nxt;
    coord_t landing_ypos_nxt;
    slope_t slope_nxt;

    // Inclusive box test on the character top-left corner
    function automatic logic in_box(
        input coord_t x,
        input coord_t y,
        input int     x0,
        input int     x1,
        input int     y0,
        input int     y1
    );
        in_box = (x >= x0) && (x <= x1) && (y >= y0) && (y <= y1);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            ladder         <= 1'b0;
            limit_ypos_min <= '0;
            limit_ypos_max <= '0;
            slope          <= SLOPE_FLAT;
            end_of_ramp    <= 1'b0;
            landing_ypos   <= '0;
        end else begin
            ladder         <= ladder_nxt;
            limit_ypos_min <= limit_ypos_min_nxt;
            limit_ypos_max <= limit_ypos_max_nxt;
            slope          <= slope_nxt;
            end_of_ramp    <= end_of_ramp_nxt;
            landing_ypos   <= landing_ypos_nxt;
        end
    end

    // Limits keep their last value outside all ladders so a climb can finish
    always_comb begin
        if (in_box(xpos, ypos, `LADDER_1_HSTART - `LADDER_OFFSET,
                   `LADDER_1_HSTART + `LADDER_WIDTH - `LADDER_OFFSET,
                   `LADDER_1_VSTART, `LADDER_1_VSTOP)) begin
            ladder_nxt         = 1'b1;
            limit_ypos_min_nxt = coord_t'(`LADDER_1_VSTART);
            limit_ypos_max_nxt = coord_t'(`LADDER_1_VSTOP);
        end else if (in_box(xpos, ypos, `LADDER_2_HSTART - `LADDER_OFFSET,
                            `LADDER_2_HSTART + `LADDER_WIDTH - `LADDER_OFFSET,
                            `LADDER_2_VSTART, `LADDER_2_VSTOP)) begin
            ladder_nxt         = 1'b1;
            limit_ypos_min_nxt = coord_t'(`LADDER_2_VSTART);
            limit_ypos_max_nxt = coord_t'(`LADDER_2_VSTOP);
        end else if (in_box(xpos, ypos, `LADDER_3_HSTART - `LADDER_OFFSET,
                            `LADDER_3_HSTART + `LADDER_WIDTH - `LADDER_OFFSET,
                            `LADDER_3_VSTART, `LADDER_3_VSTOP)) begin
            ladder_nxt         = 1'b1;
            limit_ypos_min_nxt = coord_t'(`LADDER_3_VSTART);
            limit_ypos_max_nxt = coord_t'(`LADDER_3_VSTOP);
        end else begin
            ladder_nxt         = 1'b0;
            limit_ypos_min_nxt = limit_ypos_min;
            limit_ypos_max_nxt = limit_ypos_max;
        end
    end

    always_comb begin
        if (in_box(xpos, ypos, `RAMP_1_HSTART, `RAMP_1_HSTOP,
                   `RAMP_1_VSTART, `RAMP_1_VSTOP)) begin
            slope_nxt = slope_t'(`RAMP_1_SLOPE);
        end else if (in_box(xpos, ypos, `RAMP_2_HSTART, `RAMP_2_HSTOP,
                            `RAMP_2_VSTART, `RAMP_2_VSTOP)) begin
            slope_nxt = slope_t'(`RAMP_2_SLOPE);
        end else begin
            slope_nxt = SLOPE_FLAT;
        end
    end

    always_comb begin
        if (in_box(xpos, ypos, `EOR_1_HSTART, `EOR_1_HSTOP,
                   `EOR_1_VSTART, `EOR_1_VSTOP)) begin
            end_of_ramp_nxt  = 1'b1;
            landing_ypos_nxt = coord_t'(`LANDING_1);
        end else if (in_box(xpos, ypos, `EOR_2_HSTART, `EOR_2_HSTOP,
                            `EOR_2_VSTART, `EOR_2_VSTOP)) begin
            end_of_ramp_nxt  = 1'b1;
            landing_ypos_nxt = coord_t'(`LANDING_2);
        end else begin
            end_of_ramp_nxt  = 1'b0;
            landing_ypos_nxt = landing_ypos;
        end
    end

    // A reported ladder always has a usable climbing range
    ladder_limits_ordered: assert property (
        @(posedge clk) disable iff (rst)
        ladder |-> (limit_ypos_min <= limit_ypos_max)
    ) else $error("ladder limits out of order: min %0d max %0d",
                  limit_ypos_min, limit_ypos_max);

endmodule

`default_nettype wire

//--- hw/map_pkg.sv
// Map zone and movement state types.
// The slope codes match the RAMP_n_SLOPE values in the config header.

`default_nettype none

package map_pkg;

    // A down slope means y grows while walking in that direction
    typedef enum logic [1:0] {
        SLOPE_FLAT       = 2'd0,
        SLOPE_DOWN_RIGHT = 2'd1,
        SLOPE_DOWN_LEFT  = 2'd2
    } slope_t;

    typedef enum logic [1:0] {
        ST_WALK  = 2'd0,
        ST_CLIMB = 2'd1,
        ST_FALL  = 2'd2
    } mover_state_t;

endpackage

`default_nettype wire

//--- hw/screen_pkg.sv
// Screen coordinate type and the move command set.
// Shared by the movement logic and the testbench.

`default_nettype none

package screen_pkg;

    typedef logic [10:0] coord_t;

    typedef enum logic [2:0] {
        MOVE_NONE  = 3'd0,
        MOVE_LEFT  = 3'd1,
        MOVE_RIGHT = 3'd2,
        MOVE_UP    = 3'd3,
        MOVE_DOWN  = 3'd4
    } move_t;

endpackage

`default_nettype wire

//--- hw/game_config.svh
// Build-time constants for the movement core: screen, character, step sizes and map.
// All zone edges are character top-left positions, already adjusted for the
// character height. Include this file wherever the geometry is needed.

`ifndef GAME_CONFIG_SVH
`define GAME_CONFIG_SVH

`define SCREEN_W        1024
`define SCREEN_H        768
`define CHAR_W          64
`define CHAR_H          64

`define WALK_STEP       4
`define CLIMB_STEP      2
`define FALL_STEP       4

// Character starts on the bottom floor
`define START_X         32
`define START_Y         704

`define LADDER_WIDTH    32
`define LADDER_OFFSET   16
`define LADDER_1_HSTART 880
`define LADDER_1_VSTART 560
`define LADDER_1_VSTOP  704
`define LADDER_2_HSTART 160
`define LADDER_2_VSTART 300
`define LADDER_2_VSTOP  480
`define LADDER_3_HSTART 520
`define LADDER_3_VSTART 120
`define LADDER_3_VSTOP  320

// Slope codes follow map_pkg::slope_t
`define RAMP_1_HSTART   0
`define RAMP_1_HSTOP    956
`define RAMP_1_VSTART   460
`define RAMP_1_VSTOP    700
`define RAMP_1_SLOPE    2'd1
`define RAMP_2_HSTART   64
`define RAMP_2_HSTOP    1023
`define RAMP_2_VSTART   200
`define RAMP_2_VSTOP    440
`define RAMP_2_SLOPE    2'd2

`define EOR_1_HSTART    960
`define EOR_1_HSTOP     1023
`define EOR_1_VSTART    460
`define EOR_1_VSTOP     700
`define LANDING_1       704
`define EOR_2_HSTART    0
`define EOR_2_HSTOP     60
`define EOR_2_VSTART    200
`define EOR_2_VSTOP     440
`define LANDING_2       520

`endif
